/* coreStim.txt */
# P <byte address> <instruction word>, preloaded into memory
# E <byte address> <store data> <write mask>, expected stores in program order
P 00000040 40000093
P 00000044 FFB00113
P 00000048 00300193
P 0000004C 40310233
P 00000050 0040A023
P 00000054 003152B3
P 00000058 00419313
P 0000005C 0062C3B3
P 00000060 0070A223
P 00000064 40115413
P 00000068 003124B3
P 0000006C 0021B533
P 00000070 00951533
P 00000074 00A4E5B3
P 00000078 7F047613
P 0000007C 00B60633
P 00000080 00C0A423
P 00000084 0080A623
P 00000088 123456B7
P 0000008C 00001717
P 00000090 00E687B3
P 00000094 00F0A823
P 00000098 02F08023
P 0000009C 02F080A3
P 000000A0 02F08123
P 000000A4 02F081A3
P 000000A8 02F09223
P 000000AC 02209323
P 000000B0 02108803
P 000000B4 0230C883
P 000000B8 02609903
P 000000BC 0260D983
P 000000C0 0300A823
P 000000C4 0310AA23
P 000000C8 0320AC23
P 000000CC 0330AE23
P 000000D0 00310463
P 000000D4 00318463
P 000000D8 3E00AE23
P 000000DC 00319463
P 000000E0 00311463
P 000000E4 3E00AE23
P 000000E8 0021C463
P 000000EC 00314463
P 000000F0 3E00AE23
P 000000F4 00315463
P 000000F8 0021D463
P 000000FC 3E00AE23
P 00000100 00316463
P 00000104 0021E463
P 00000108 3E00AE23
P 0000010C 0021F463
P 00000110 00317463
P 00000114 3E00AE23
P 00000118 05A00A93
P 0000011C 0550A023
P 00000120 00800B6F
P 00000124 3E00AE23
P 00000128 0560A223
P 0000012C 13800C13
P 00000130 001C0BE7
P 00000134 3E00AE23
P 00000138 0570A423
P 0000013C 3E00AE23
P 00000140 0000006F
E 00000400 FFFFFFF8 F
E 00000404 1FFFFFCF F
E 00000408 000007F3 F
E 0000040C FFFFFFFD F
E 00000410 1234608C F
E 00000420 0000008C 1
E 00000421 00008C00 2
E 00000422 008C0000 4
E 00000423 8C000000 8
E 00000424 0000608C 3
E 00000426 FFFB0000 C
E 00000430 FFFFFF8C F
E 00000434 0000008C F
E 00000438 FFFFFFFB F
E 0000043C 0000FFFB F
E 00000440 0000005A F
E 00000444 00000124 F
E 00000448 00000134 F

/* compile.f */
rvCorePkg.sv
instrDecoder.sv
registerFile.sv
aluUnit.sv
loadStoreUnit.sv
fetchExecuteSequencer.sv
femtoCore.sv
tbMemory.sv
femtoCoreTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f compile.f --top-module femtoCoreTb -o femtoCoreTb
	./obj_dir/femtoCoreTb | tee /dev/stderr | grep -q "test passed"

clean:
	rm -rf obj_dir

/* femtoCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module femtoCoreTb;
   import rvCorePkg::*;

   localparam int          memWords      = 1024;
   localparam int          indexWidth    = $clog2(memWords);
   localparam logic [31:0] resetAddr     = 32'h0000_0040;
   localparam logic [31:0] doneAddr      = 32'h0000_07FC;
   localparam int          cyclesPerWord = 40;

   logic        clk;
   logic        reset;
   memReqT      memReq;
   logic [31:0] memRdata;
   logic        memRbusy;
   logic        memWbusy;
   logic [1:0]  maxWait;
   logic        load;
   logic [31:0] image [memWords];
   logic [31:0] storeCount;

   // Program and expected stores from the stim file
   logic [31:0] progAddr [$];
   logic [31:0] progWord [$];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   logic [3:0]  expMask [$];

   int errorCount;
   int passCount;
   int failCount;
   int storeIndex;
   int cycleCount;
   int cycleLimit;
   bit running;
   bit doneSeen;
   bit fetchSeen;

   femtoCore #(
      .addrWidth (24),
      .resetAddr (resetAddr)
   ) i_dut (
      .clk      (clk),
      .reset    (reset),
      .memReq   (memReq),
      .memRdata (memRdata),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   tbMemory #(
      .memWords (memWords)
   ) i_mem (
      .clk        (clk),
      .memReq     (memReq),
      .maxWait    (maxWait),
      .load       (load),
      .image      (image),
      .memRdata   (memRdata),
      .memRbusy   (memRbusy),
      .memWbusy   (memWbusy),
      .storeCount (storeCount)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic compareValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      if (expected !== actual) begin
         errorCount++;
         $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // Byte-lane mask widened to a bit mask
   function automatic logic [31:0] laneBits(input logic [3:0] mask);
      return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
   endfunction

   task automatic readStim();
      int          fd;
      int          code;
      string       line;
      logic [31:0] a;
      logic [31:0] d;
      logic [3:0]  m;
      fd = $fopen("coreStim.txt", "r");
      if (fd == 0) begin
         errorCount++;
         $display("could not open the stimulus file coreStim.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Nothing left to read
            if (code == 0) begin
               break;
            end
            if ($sscanf(line, "P %h %h", a, d) == 2) begin
               progAddr.push_back(a);
               progWord.push_back(d);
            end else if ($sscanf(line, "E %h %h %h", a, d, m) == 3) begin
               expAddr.push_back(a);
               expData.push_back(d);
               expMask.push_back(m);
            end
         end
         $fclose(fd);
      end
   endtask

   // Load a fresh memory image, hold reset for 3 cycles and run until the done store
   task automatic runProgram(input int run, input logic [1:0] waits);
      int errorsBefore;
      errorsBefore = errorCount;
      for (int i = 0; i < memWords; i++) begin
         image[i] = 32'(i) * 32'h9E37_79B1;
      end
      foreach (progAddr[i]) begin
         image[progAddr[i][indexWidth+1:2]] = progWord[i];
      end
      cycleLimit = cyclesPerWord * progWord.size();
      @(posedge clk);
      // Monitor is idle from here on, so its counters can be cleared
      storeIndex = 0;
      cycleCount = 0;
      doneSeen   = 1'b0;
      fetchSeen  = 1'b0;
      reset   <= 1'b0;
      load    <= 1'b1;
      maxWait <= waits;
      @(posedge clk);
      load <= 1'b0;
      @(posedge clk);
      @(posedge clk);
      reset   <= 1'b1;
      running <= 1'b1;
      while (!doneSeen) begin
         @(posedge clk);
      end
      running <= 1'b0;
      if (storeIndex != expAddr.size()) begin
         errorCount++;
         $display("run %0d ended after %0d of %0d expected stores",
                  run, storeIndex, expAddr.size());
      end
      if (errorCount == errorsBefore) begin
         passCount++;
         $display("run %0d, up to %0d busy cycles: %0d stores, ok", run, waits, storeCount);
      end else begin
         failCount++;
         $display("run %0d, up to %0d busy cycles: %0d errors", run, waits,
                  errorCount - errorsBefore);
      end
   endtask

   // Bus monitor for the reset vector, the store order and the cycle limit
   always @(posedge clk) begin
      if (running) begin
         cycleCount++;
         if (memReq.rstrb && !fetchSeen) begin
            fetchSeen = 1'b1;
            compareValue("memReq.addr", resetAddr, memReq.addr);
         end
         if (memReq.wmask != 4'b0000) begin
            if (!fetchSeen) begin
               errorCount++;
               $display("a store appeared before the first fetch");
            end
            if (memReq.addr == doneAddr) begin
               doneSeen <= 1'b1;
            end else if (storeIndex >= expAddr.size()) begin
               errorCount++;
               $display("unexpected extra store to address %h", memReq.addr);
            end else begin
               compareValue("memReq.addr", expAddr[storeIndex], memReq.addr);
               compareValue("memReq.wmask", 32'(expMask[storeIndex]), 32'(memReq.wmask));
               // Only the written lanes carry meaning
               compareValue("memReq.wdata",
                            expData[storeIndex] & laneBits(expMask[storeIndex]),
                            memReq.wdata & laneBits(expMask[storeIndex]));
               storeIndex++;
            end
         end
         if (cycleCount >= cycleLimit) begin
            $display("timeout: no done store after %0d cycles", cycleCount);
            $display("test failed");
            $finish;
         end
      end
   end

   initial begin
      reset      = 1'b0;
      load       = 1'b0;
      maxWait    = 2'd0;
      running    = 1'b0;
      errorCount = 0;
      passCount  = 0;
      failCount  = 0;
      void'($urandom(19));
      readStim();
      if (errorCount == 0) begin
         runProgram(0, 2'd0);
         runProgram(1, 2'd3);
      end
      $display("%0d runs passed, %0d runs failed, %0d errors",
               passCount, failCount, errorCount);
      if (errorCount == 0 && failCount == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tbMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module tbMemory #(
   parameter int memWords = 1024
) (
   input  wire                         clk,
   input  wire  rvCorePkg::memReqT     memReq,
   input  wire  [1:0]                  maxWait,
   input  wire                         load,
   input  wire  [31:0]                 image [memWords],
   output logic [31:0]                 memRdata,
   output logic                        memRbusy,
   output logic                        memWbusy,
   output logic [31:0]                 storeCount
);
   import rvCorePkg::*;

   localparam int indexWidth = $clog2(memWords);

   logic [31:0]           words [memWords];
   logic [indexWidth-1:0] reqIndex;
   logic [indexWidth-1:0] readIndex;
   logic [1:0]            readWait;
   logic [1:0]            writeWait;

   // Byte address to word index, upper bits ignored
   assign reqIndex = memReq.addr[indexWidth+1:2];

   initial begin
      memRdata   = '0;
      memRbusy   = 1'b0;
      memWbusy   = 1'b0;
      storeCount = '0;
      readWait   = '0;
      writeWait  = '0;
   end

   always @(posedge clk) begin
      logic [1:0] newWait;
      // Busy length for an access starting now, 0 to maxWait cycles
      newWait = 2'($urandom % (32'(maxWait) + 32'd1));
      if (load) begin
         for (int i = 0; i < memWords; i++) begin
            words[i] <= image[i];
         end
         memRbusy   <= 1'b0;
         memWbusy   <= 1'b0;
         readWait   <= '0;
         writeWait  <= '0;
         storeCount <= '0;
      end else begin
         // Read: data shows up on the cycle busy drops
         if (memReq.rstrb) begin
            readIndex <= reqIndex;
            readWait  <= newWait;
            memRbusy  <= (newWait != 2'd0);
            if (newWait == 2'd0) begin
               memRdata <= words[reqIndex];
            end
         end else if (readWait != 2'd0) begin
            readWait <= readWait - 2'd1;
            memRbusy <= (readWait != 2'd1);
            if (readWait == 2'd1) begin
               memRdata <= words[readIndex];
            end
         end
         // Write: byte lanes under the mask, counted as one store
         if (memReq.wmask != 4'b0000) begin
            for (int b = 0; b < 4; b++) begin
               if (memReq.wmask[b]) begin
                  words[reqIndex][8*b +: 8] <= memReq.wdata[8*b +: 8];
               end
            end
            storeCount <= storeCount + 32'd1;
            writeWait  <= newWait;
            memWbusy   <= (newWait != 2'd0);
         end else if (writeWait != 2'd0) begin
            writeWait <= writeWait - 2'd1;
            memWbusy  <= (writeWait != 2'd1);
         end
      end
   end

endmodule

`default_nettype wire

/* femtoCore.sv */
`timescale 1ns/10ps
`default_nettype none

module femtoCore #(
   parameter int                              addrWidth = 24,
   parameter logic [rvCorePkg::dataWidth-1:0] resetAddr = '0
) (
   input  wire                             clk,
   input  wire                             reset,
   output rvCorePkg::memReqT               memReq,
   input  wire  [rvCorePkg::dataWidth-1:0] memRdata,
   input  wire                             memRbusy,
   input  wire                             memWbusy
);
   import rvCorePkg::*;

   logic [dataWidth-1:2]    instrWord;
   decodedInstrT            decoded;
   logic                    accept;
   logic                    writeEnable;
   logic [regAddrWidth-1:0] rdIndex;
   logic [dataWidth-1:0]    writeData;
   logic [dataWidth-1:0]    rs1;
   logic [dataWidth-1:0]    rs2;
   logic [dataWidth-1:0]    aluResult;
   logic [dataWidth-1:0]    aluSum;
   logic                    branchTaken;
   logic [addrWidth-1:0]    lsAddr;
   logic [dataWidth-1:0]    storeData;
   logic [3:0]              storeMask;
   logic [dataWidth-1:0]    loadData;

   instrDecoder i_instrDecoder (
      .instrWord (instrWord),
      .decoded   (decoded)
   );

   // Source indices come straight off the bus, before the latch fills
   registerFile i_registerFile (
      .clk         (clk),
      .accept      (accept),
      .rs1Index    (memRdata[19:15]),
      .rs2Index    (memRdata[24:20]),
      .writeEnable (writeEnable),
      .rdIndex     (rdIndex),
      .writeData   (writeData),
      .rs1         (rs1),
      .rs2         (rs2)
   );

   aluUnit i_aluUnit (
      .decoded     (decoded),
      .rs1         (rs1),
      .rs2         (rs2),
      .aluResult   (aluResult),
      .aluSum      (aluSum),
      .branchTaken (branchTaken)
   );

   loadStoreUnit #(
      .addrWidth (addrWidth)
   ) i_loadStoreUnit (
      .decoded   (decoded),
      .rs1       (rs1),
      .rs2       (rs2),
      .memRdata  (memRdata),
      .lsAddr    (lsAddr),
      .storeData (storeData),
      .storeMask (storeMask),
      .loadData  (loadData)
   );

   fetchExecuteSequencer #(
      .addrWidth (addrWidth),
      .resetAddr (resetAddr)
   ) i_fetchExecuteSequencer (
      .clk         (clk),
      .reset       (reset),
      .memRbusy    (memRbusy),
      .memWbusy    (memWbusy),
      .memRdata    (memRdata),
      .decoded     (decoded),
      .rs1         (rs1),
      .aluResult   (aluResult),
      .aluSum      (aluSum),
      .branchTaken (branchTaken),
      .lsAddr      (lsAddr),
      .storeData   (storeData),
      .storeMask   (storeMask),
      .loadData    (loadData),
      .instrWord   (instrWord),
      .accept      (accept),
      .writeEnable (writeEnable),
      .rdIndex     (rdIndex),
      .writeData   (writeData),
      .memReq      (memReq)
   );

endmodule

`default_nettype wire

/* fetchExecuteSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchExecuteSequencer #(
   parameter int                              addrWidth = 24,
   parameter logic [rvCorePkg::dataWidth-1:0] resetAddr = '0
) (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                memRbusy,
   input  wire                                memWbusy,
   input  wire  [rvCorePkg::dataWidth-1:0]    memRdata,
   input  wire  rvCorePkg::decodedInstrT      decoded,
   input  wire  [rvCorePkg::dataWidth-1:0]    rs1,
   input  wire  [rvCorePkg::dataWidth-1:0]    aluResult,
   input  wire  [rvCorePkg::dataWidth-1:0]    aluSum,
   input  wire                                branchTaken,
   input  wire  [addrWidth-1:0]               lsAddr,
   input  wire  [rvCorePkg::dataWidth-1:0]    storeData,
   input  wire  [3:0]                         storeMask,
   input  wire  [rvCorePkg::dataWidth-1:0]    loadData,
   output logic [rvCorePkg::dataWidth-1:2]    instrWord,
   output logic                               accept,
   output logic                               writeEnable,
   output logic [rvCorePkg::regAddrWidth-1:0] rdIndex,
   output logic [rvCorePkg::dataWidth-1:0]    writeData,
   output rvCorePkg::memReqT                  memReq
);
   import rvCorePkg::*;

   coreStateT            state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcImm;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] jalrTarget;
   logic [addrWidth-1:0] nextPc;
   logic                 isLoad;
   logic                 isStore;
   logic                 isBranch;
   logic                 isJal;
   logic                 isJalr;
   logic                 isAuipc;
   logic                 jumpRel;

   assign isLoad   = (decoded.opcode == opLoad);
   assign isStore  = (decoded.opcode == opStore);
   assign isBranch = (decoded.opcode == opBranch);
   assign isJal    = (decoded.opcode == opJal);
   assign isJalr   = (decoded.opcode == opJalr);
   assign isAuipc  = (decoded.opcode == opAuipc);

   assign pcPlus4 = pc + addrWidth'(4);

   // One PC-relative adder for JAL, AUIPC and branches
   assign pcImm     = isJal   ? decoded.immJ[addrWidth-1:0] :
                      isAuipc ? decoded.immU[addrWidth-1:0] :
                      decoded.immB[addrWidth-1:0];
   assign pcPlusImm = pc + pcImm;

   // rs1 + I-immediate from the ALU adder with bit 0 forced low
   assign jalrTarget = {aluSum[addrWidth-1:1], 1'b0};
   assign jumpRel    = isJal | (isBranch & branchTaken);
   assign nextPc     = isJalr  ? jalrTarget :
                       jumpRel ? pcPlusImm : pcPlus4;

   // Register read happens together with the instruction latch
   assign accept = (state == stWaitInstr) && !memRbusy;

   // Loads keep writing while waiting so the settled word lands last
   assign writeEnable = !(isBranch | isStore) &&
                        ((state == stExecute) || (state == stWaitMem));
   assign rdIndex     = decoded.rd;

   always_comb begin
      case (decoded.opcode)
         opLui:             writeData = decoded.immU;
         opAuipc:           writeData = dataWidth'(pcPlusImm);
         opJal, opJalr:     writeData = dataWidth'(pcPlus4);
         opAluReg, opAluImm: writeData = aluResult;
         opLoad:            writeData = loadData;
         // Unrecognised opcodes write zero
         default:           writeData = '0;
      endcase
   end

   // PC on the bus while fetching and the data address after that
   always_comb begin
      memReq.addr  = ((state == stFetch) || (state == stWaitInstr)) ?
                     dataWidth'(pc) : dataWidth'(lsAddr);
      memReq.wdata = storeData;
      // Write is a single-cycle pulse in execute
      memReq.wmask = {4{(state == stExecute) && isStore}} & storeMask;
      memReq.rstrb = (state == stFetch) || ((state == stExecute) && isLoad);
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start in the wait state so a pending write can drain
         state     <= stWaitMem;
         pc        <= resetAddr[addrWidth-1:0];
         // All-zero word decodes as a load into x0, so nothing is written
         instrWord <= '0;
      end else begin
         case (state)
            stFetch: begin
               state <= stWaitInstr;
            end
            stWaitInstr: begin
               if (!memRbusy) begin
                  instrWord <= memRdata[dataWidth-1:2];
                  state     <= stExecute;
               end
            end
            stExecute: begin
               pc    <= nextPc;
               state <= (isLoad || isStore) ? stWaitMem : stFetch;
            end
            stWaitMem: begin
               if (!memRbusy && !memWbusy) begin
                  state <= stFetch;
               end
            end
            default: begin
               state <= stFetch;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* loadStoreUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module loadStoreUnit #(
   parameter int addrWidth = 24
) (
   input  wire  rvCorePkg::decodedInstrT   decoded,
   input  wire  [rvCorePkg::dataWidth-1:0] rs1,
   input  wire  [rvCorePkg::dataWidth-1:0] rs2,
   input  wire  [rvCorePkg::dataWidth-1:0] memRdata,
   output logic [addrWidth-1:0]            lsAddr,
   output logic [rvCorePkg::dataWidth-1:0] storeData,
   output logic [3:0]                      storeMask,
   output logic [rvCorePkg::dataWidth-1:0] loadData
);
   import rvCorePkg::*;

   logic           byteAccess;
   logic           halfAccess;
   logic [15:0]    loadHalf;
   logic [7:0]     loadByte;
   logic           loadSign;

   // funct3[1:0] gives the access size, 00 byte, 01 half, 10 word
   assign byteAccess = (decoded.funct3[1:0] == 2'b00);
   assign halfAccess = (decoded.funct3[1:0] == 2'b01);

   // Stores take the S-immediate, loads the I-immediate
   assign lsAddr = rs1[addrWidth-1:0] + ((decoded.opcode == opStore) ?
                   decoded.immS[addrWidth-1:0] : decoded.immI[addrWidth-1:0]);

   // Low byte or halfword copied into every lane it may land in
   // The mask then selects the lanes actually written
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = lsAddr[0] ? rs2[7:0] :
                             lsAddr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << lsAddr[1:0];
      end else if (halfAccess) begin
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

   // Pick the halfword, then the byte within it
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // LBU and LHU have funct3 bit 2 set and zero-extend
   assign loadSign = !decoded.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                     memRdata;

endmodule

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
   input  wire  rvCorePkg::decodedInstrT   decoded,
   input  wire  [rvCorePkg::dataWidth-1:0] rs1,
   input  wire  [rvCorePkg::dataWidth-1:0] rs2,
   output logic [rvCorePkg::dataWidth-1:0] aluResult,
   output logic [rvCorePkg::dataWidth-1:0] aluSum,
   output logic                            branchTaken
);
   import rvCorePkg::*;

   logic [dataWidth-1:0]        aluIn2;
   logic [dataWidth:0]          aluMinus;
   logic                        lessThan;
   logic                        lessThanU;
   logic                        equal;
   logic [dataWidth-1:0]        rs1Reversed;
   logic [dataWidth-1:0]        shifterIn;
   logic signed [dataWidth:0]   shiftWide;
   logic [dataWidth-1:0]        shifter;
   logic [dataWidth-1:0]        leftShift;

   // Register operand for R-type and branches, I-immediate for the rest
   assign aluIn2 = (decoded.opcode == opAluReg || decoded.opcode == opBranch) ?
                   rs2 : decoded.immI;

   // Also the JALR target, since JALR takes the I-immediate
   assign aluSum = rs1 + aluIn2;

   // One 33-bit subtract serves SUB and every compare
   // Bit 32 is the borrow, set when rs1 < aluIn2 unsigned
   assign aluMinus  = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign lessThanU = aluMinus[dataWidth];
   // Signs differ: the negative one is smaller
   assign lessThan  = (rs1[dataWidth-1] ^ aluIn2[dataWidth-1]) ?
                      rs1[dataWidth-1] : aluMinus[dataWidth];
   assign equal     = (aluMinus[dataWidth-1:0] == '0);

   // Left shift = reverse, shift right, reverse again
   assign rs1Reversed = {<<{rs1}};
   assign shifterIn   = (decoded.funct3 == 3'b001) ? rs1Reversed : rs1;
   // Extra top bit carries the sign in for SRA/SRAI
   assign shiftWide   = $signed({decoded.funct7Bit & rs1[dataWidth-1], shifterIn})
                        >>> aluIn2[4:0];
   assign shifter     = shiftWide[dataWidth-1:0];
   assign leftShift   = {<<{shifter}};

   always_comb begin
      case (decoded.funct3)
         // ADDI shares bit 30 with its immediate, so SUB needs R-type too
         3'b000:  aluResult = (decoded.opcode == opAluReg && decoded.funct7Bit) ?
                              aluMinus[dataWidth-1:0] : aluSum;
         3'b001:  aluResult = leftShift;
         3'b010:  aluResult = {{(dataWidth-1){1'b0}}, lessThan};
         3'b011:  aluResult = {{(dataWidth-1){1'b0}}, lessThanU};
         3'b100:  aluResult = rs1 ^ aluIn2;
         3'b101:  aluResult = shifter;
         3'b110:  aluResult = rs1 | aluIn2;
         default: aluResult = rs1 & aluIn2;
      endcase
   end

   // Branch condition from funct3, 010 and 011 are not branches
   always_comb begin
      case (decoded.funct3)
         3'b000:  branchTaken = equal;
         3'b001:  branchTaken = !equal;
         3'b100:  branchTaken = lessThan;
         3'b101:  branchTaken = !lessThan;
         3'b110:  branchTaken = lessThanU;
         3'b111:  branchTaken = !lessThanU;
         default: branchTaken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

module registerFile (
   input  wire                                clk,
   input  wire                                accept,
   input  wire  [rvCorePkg::regAddrWidth-1:0] rs1Index,
   input  wire  [rvCorePkg::regAddrWidth-1:0] rs2Index,
   input  wire                                writeEnable,
   input  wire  [rvCorePkg::regAddrWidth-1:0] rdIndex,
   input  wire  [rvCorePkg::dataWidth-1:0]    writeData,
   output logic [rvCorePkg::dataWidth-1:0]    rs1,
   output logic [rvCorePkg::dataWidth-1:0]    rs2
);
   import rvCorePkg::*;

   logic [dataWidth-1:0] regs [2**regAddrWidth];

   // x0 is never written
   always_ff @(posedge clk) begin
      if (writeEnable && (rdIndex != '0)) begin
         regs[rdIndex] <= writeData;
      end
   end

   // Both sources captured on the cycle the instruction word arrives
   // Entry zero is never written, so its read is forced to zero
   always_ff @(posedge clk) begin
      if (accept) begin
         rs1 <= (rs1Index == '0) ? '0 : regs[rs1Index];
         rs2 <= (rs2Index == '0) ? '0 : regs[rs2Index];
      end
   end

endmodule

`default_nettype wire

/* instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
   input  wire [rvCorePkg::dataWidth-1:2] instrWord,
   output rvCorePkg::decodedInstrT        decoded
);
   import rvCorePkg::*;

   opcodeT opcode;

   // Bits 1 and 0 are always 11 in RV32I, so only bits 6 to 2 matter
   always_comb begin
      case (instrWord[6:2])
         5'b00000: opcode = opLoad;
         5'b00100: opcode = opAluImm;
         5'b00101: opcode = opAuipc;
         5'b01000: opcode = opStore;
         5'b01100: opcode = opAluReg;
         5'b01101: opcode = opLui;
         5'b11000: opcode = opBranch;
         5'b11001: opcode = opJalr;
         5'b11011: opcode = opJal;
         // SYSTEM and everything else falls here
         default:  opcode = opUnknown;
      endcase
   end

   always_comb begin
      decoded.opcode    = opcode;
      decoded.funct3    = instrWord[14:12];
      // Bit 30 picks SUB over ADD and arithmetic over logical right shift
      decoded.funct7Bit = instrWord[30];
      decoded.rd        = instrWord[11:7];

      // Sign bit is always instruction bit 31
      decoded.immI = {{21{instrWord[31]}}, instrWord[30:20]};
      decoded.immS = {{21{instrWord[31]}}, instrWord[30:25], instrWord[11:7]};
      // Branch offsets are in halfwords, bit 0 is implicit zero
      decoded.immB = {{20{instrWord[31]}}, instrWord[7], instrWord[30:25],
                      instrWord[11:8], 1'b0};
      // Upper immediate fills bits 31 to 12
      decoded.immU = {instrWord[31:12], 12'b0};
      decoded.immJ = {{12{instrWord[31]}}, instrWord[19:12], instrWord[20],
                      instrWord[30:21], 1'b0};
   end

endmodule

`default_nettype wire

/* rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

   // Data path and register index widths
   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 5;

   // Opcode groups of the RV32I base set, taken from instruction bits 6 to 2
   typedef enum logic [3:0] {
      opLoad,
      opAluImm,
      opAuipc,
      opStore,
      opAluReg,
      opLui,
      opBranch,
      opJalr,
      opJal,
      opUnknown
   } opcodeT;

   // One bit per state keeps the state decode shallow
   typedef enum logic [3:0] {
      stFetch     = 4'b0001,
      stWaitInstr = 4'b0010,
      stExecute   = 4'b0100,
      stWaitMem   = 4'b1000
   } coreStateT;

   // Everything the datapath needs from one instruction word
   typedef struct packed {
      opcodeT                  opcode;
      logic [2:0]              funct3;
      logic                    funct7Bit;   // SUB and SRA/SRAI select
      logic [regAddrWidth-1:0] rd;
      logic [dataWidth-1:0]    immI;
      logic [dataWidth-1:0]    immS;
      logic [dataWidth-1:0]    immB;
      logic [dataWidth-1:0]    immU;
      logic [dataWidth-1:0]    immJ;
   } decodedInstrT;

   // Single shared bus request, instructions and data alike
   typedef struct packed {
      logic [dataWidth-1:0] addr;
      logic [dataWidth-1:0] wdata;
      logic [3:0]           wmask;
      logic                 rstrb;
   } memReqT;

endpackage

`default_nettype wire
